// File: tpu_data_pkg.sv
`default_nettype none

package tpu_data_pkg;

	//////////////////////////////////////////////////////////////
	// Word and index widths
	//////////////////////////////////////////////////////////////

	localparam int DATA_W   = 32;					// Operand and result word
	localparam int INDEX_W  = 4;					// Register index bits
	localparam int NUM_REGS = 1 << INDEX_W;			// Lane register file depth

	//////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////

	typedef logic [DATA_W-1:0]  data_t;				// Datapath word
	typedef logic [INDEX_W-1:0] index_t;			// Register file address

endpackage

`default_nettype wire

// File: tpu_ctrl_pkg.sv
`default_nettype none

package tpu_ctrl_pkg;

	//////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_ADD,										// src1 + src2
		OP_SUB,										// src1 - src2
		OP_MUL,										// Low word of src1 * src2
		OP_MAD,										// Low word of src1 * src2 + src3
		OP_IMM										// Immediate pass
	} op_t;

	// Path select, shared by writeback and PAC muxes
	typedef logic [1:0] path_t;

	localparam path_t PATH_ALU  = 2'd0;				// ALU for writeback, none for PAC
	localparam path_t PATH_SRC1 = 2'd1;				// Source operand 1
	localparam path_t PATH_SRC2 = 2'd2;				// Source operand 2
	localparam path_t PATH_SRC3 = 2'd3;				// Source operand 3

	localparam int BYPASS_BUFF_SIZE = 4;			// Default bypass depth

endpackage

`default_nettype wire

// File: lane_issue.sv
`default_nettype none

module lane_issue (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					req,
	input  logic					buff_full,			// Only for issue rule check
	input  tpu_ctrl_pkg::op_t		op,
	input  tpu_data_pkg::data_t		imm,
	input  tpu_ctrl_pkg::path_t		sel_path,			// PAC select
	input  tpu_ctrl_pkg::path_t		sel_path_wb,		// Writeback select
	input  tpu_data_pkg::index_t	src_idx1,
	input  tpu_data_pkg::index_t	src_idx2,
	input  tpu_data_pkg::index_t	src_idx3,
	input  tpu_data_pkg::index_t	dst_idx,
	input  tpu_data_pkg::index_t	rd_idx1,			// Read ports from network
	input  tpu_data_pkg::index_t	rd_idx2,
	input  tpu_data_pkg::index_t	rd_idx3,
	input  logic					ret_valid,			// Retire write port
	input  tpu_data_pkg::index_t	ret_idx,
	input  tpu_data_pkg::data_t		ret_data,
	output logic					iss_valid,
	output tpu_ctrl_pkg::op_t		iss_op,
	output tpu_data_pkg::data_t		iss_imm,
	output tpu_ctrl_pkg::path_t		iss_sel_path,
	output tpu_ctrl_pkg::path_t		iss_sel_path_wb,
	output tpu_data_pkg::index_t	iss_src_idx1,
	output tpu_data_pkg::index_t	iss_src_idx2,
	output tpu_data_pkg::index_t	iss_src_idx3,
	output tpu_data_pkg::index_t	iss_dst_idx,
	output tpu_data_pkg::data_t		rd_data1,
	output tpu_data_pkg::data_t		rd_data2,
	output tpu_data_pkg::data_t		rd_data3
);

	tpu_data_pkg::data_t	rf [tpu_data_pkg::NUM_REGS];	// Lane register file

	//////////////////////////////////////////////////////////////
	// Issue registers
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst)
			iss_valid <= 1'b0;
		else if (!stall)
			iss_valid <= req;						// Bubble when no request
	end

	always_ff @(posedge clock) begin
		if (!stall) begin							// Hold fields under stall
			iss_op          <= op;
			iss_imm         <= imm;
			iss_sel_path    <= sel_path;
			iss_sel_path_wb <= sel_path_wb;
			iss_src_idx1    <= src_idx1;
			iss_src_idx2    <= src_idx2;
			iss_src_idx3    <= src_idx3;
			iss_dst_idx     <= dst_idx;
		end
	end

	//////////////////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < tpu_data_pkg::NUM_REGS; i++)
				rf[i] <= '0;						// All registers read zero
		end else if (ret_valid) begin
			rf[ret_idx] <= ret_data;				// Oldest bypass entry lands
		end
	end

	assign rd_data1 = rf[rd_idx1];					// Combinational reads
	assign rd_data2 = rf[rd_idx2];
	assign rd_data3 = rf[rd_idx3];

	// Issuer must hold off while the lane stalls or the buffer is full
	a_req_idle: assert property (@(posedge clock) disable iff (rst)
		(stall || buff_full) |-> !req);

endmodule

`default_nettype wire

// File: bypass_buff.sv
`default_nettype none

module bypass_buff #(
	parameter int BUFF_SIZE = tpu_ctrl_pkg::BYPASS_BUFF_SIZE
) (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					wb_valid,			// Result from exec stage
	input  tpu_data_pkg::index_t	wb_idx,
	input  tpu_data_pkg::data_t		wb_data,
	input  tpu_data_pkg::index_t	idx1,				// Source lookups
	input  tpu_data_pkg::index_t	idx2,
	input  tpu_data_pkg::index_t	idx3,
	input  tpu_data_pkg::data_t		src1,				// Register file values
	input  tpu_data_pkg::data_t		src2,
	input  tpu_data_pkg::data_t		src3,
	output tpu_data_pkg::data_t		out1,				// Forwarded operands
	output tpu_data_pkg::data_t		out2,
	output tpu_data_pkg::data_t		out3,
	output logic					full,
	output logic					ret_valid,			// Retire port to register file
	output tpu_data_pkg::index_t	ret_idx,
	output tpu_data_pkg::data_t		ret_data
);

	localparam int CNT_W = $clog2(BUFF_SIZE + 1);

	tpu_data_pkg::index_t	ent_idx  [BUFF_SIZE];	// Entry 0 is oldest
	tpu_data_pkg::data_t	ent_data [BUFF_SIZE];
	logic [CNT_W-1:0]		cnt;					// Valid entries
	logic [CNT_W-1:0]		wr_pos;
	logic					do_wr;
	logic					do_ret;

	// Newest match wins
	// Exec output counts as newer than any entry
	function automatic tpu_data_pkg::data_t fwd_val(input tpu_data_pkg::index_t idx,
			input tpu_data_pkg::data_t src);
		tpu_data_pkg::data_t val;
		val = src;
		for (int i = 0; i < BUFF_SIZE; i++) begin
			if ((i < int'(cnt)) && (ent_idx[i] == idx))
				val = ent_data[i];				// Later entries override
		end
		if (wb_valid && (wb_idx == idx))
			val = wb_data;
		return val;
	endfunction

	//////////////////////////////////////////////////////////////
	// FIFO control
	//////////////////////////////////////////////////////////////

	assign do_wr  = wb_valid && !stall;				// One write per result
	assign do_ret = (cnt != '0) && !stall;
	assign wr_pos = do_ret ? cnt - 1'b1 : cnt;		// Slot after the shift
	assign full   = (int'(cnt) == BUFF_SIZE);

	always_ff @(posedge clock) begin
		if (rst)
			cnt <= '0;
		else
			cnt <= cnt + CNT_W'(do_wr) - CNT_W'(do_ret);
	end

	always_ff @(posedge clock) begin
		if (do_ret) begin
			for (int i = 0; i < BUFF_SIZE - 1; i++) begin
				ent_idx[i]  <= ent_idx[i + 1];		// Shift toward head
				ent_data[i] <= ent_data[i + 1];
			end
		end
		for (int i = 0; i < BUFF_SIZE; i++) begin
			if (do_wr && (int'(wr_pos) == i)) begin
				ent_idx[i]  <= wb_idx;
				ent_data[i] <= wb_data;
			end
		end
	end

	assign ret_valid = do_ret;
	assign ret_idx   = ent_idx[0];
	assign ret_data  = ent_data[0];

	//////////////////////////////////////////////////////////////
	// Operand forwarding
	//////////////////////////////////////////////////////////////

	always_comb begin
		out1 = fwd_val(idx1, src1);
		out2 = fwd_val(idx2, src2);
		out3 = fwd_val(idx3, src3);
	end

	// A pushed result always lands inside the entry array
	a_wr_in_range: assert property (@(posedge clock) disable iff (rst)
		do_wr |-> (int'(wr_pos) < BUFF_SIZE));

endmodule

`default_nettype wire

// File: operand_network.sv
`default_nettype none

module operand_network #(
	parameter int BUFF_SIZE = tpu_ctrl_pkg::BYPASS_BUFF_SIZE
) (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					iss_valid,
	input  tpu_ctrl_pkg::op_t		iss_op,
	input  tpu_data_pkg::data_t		iss_imm,
	input  tpu_ctrl_pkg::path_t		iss_sel_path,
	input  tpu_ctrl_pkg::path_t		iss_sel_path_wb,
	input  tpu_data_pkg::index_t	iss_src_idx1,
	input  tpu_data_pkg::index_t	iss_src_idx2,
	input  tpu_data_pkg::index_t	iss_src_idx3,
	input  tpu_data_pkg::index_t	iss_dst_idx,
	input  tpu_data_pkg::data_t		rd_data1,
	input  tpu_data_pkg::data_t		rd_data2,
	input  tpu_data_pkg::data_t		rd_data3,
	input  logic					wb_valid,
	input  tpu_data_pkg::index_t	wb_idx,
	input  tpu_data_pkg::data_t		wb_data,
	output tpu_data_pkg::index_t	rd_idx1,
	output tpu_data_pkg::index_t	rd_idx2,
	output tpu_data_pkg::index_t	rd_idx3,
	output logic					opr_valid,
	output tpu_ctrl_pkg::op_t		opr_op,
	output tpu_data_pkg::data_t		opr_imm,
	output tpu_data_pkg::data_t		opr_src1,
	output tpu_data_pkg::data_t		opr_src2,
	output tpu_data_pkg::data_t		opr_src3,
	output tpu_ctrl_pkg::path_t		opr_sel_path,
	output tpu_ctrl_pkg::path_t		opr_sel_path_wb,
	output tpu_data_pkg::index_t	opr_dst_idx,
	output logic					buff_full,
	output logic					ret_valid,
	output tpu_data_pkg::index_t	ret_idx,
	output tpu_data_pkg::data_t		ret_data
);

	tpu_data_pkg::data_t	fwd1;					// Operands after bypass
	tpu_data_pkg::data_t	fwd2;
	tpu_data_pkg::data_t	fwd3;

	assign rd_idx1 = iss_src_idx1;					// Same index to RF and buffer
	assign rd_idx2 = iss_src_idx2;
	assign rd_idx3 = iss_src_idx3;

	bypass_buff #(
		.BUFF_SIZE	(BUFF_SIZE)
	) i_bypass_buff (
		.clock		(clock),
		.rst		(rst),
		.stall		(stall),
		.wb_valid	(wb_valid),
		.wb_idx		(wb_idx),
		.wb_data	(wb_data),
		.idx1		(iss_src_idx1),
		.idx2		(iss_src_idx2),
		.idx3		(iss_src_idx3),
		.src1		(rd_data1),
		.src2		(rd_data2),
		.src3		(rd_data3),
		.out1		(fwd1),
		.out2		(fwd2),
		.out3		(fwd3),
		.full		(buff_full),
		.ret_valid	(ret_valid),
		.ret_idx	(ret_idx),
		.ret_data	(ret_data)
	);

	always_ff @(posedge clock) begin
		if (rst)
			opr_valid <= 1'b0;
		else if (!stall)
			opr_valid <= iss_valid;
	end

	always_ff @(posedge clock) begin
		if (!stall) begin							// Operand registers
			opr_op          <= iss_op;
			opr_imm         <= iss_imm;
			opr_src1        <= fwd1;
			opr_src2        <= fwd2;
			opr_src3        <= fwd3;
			opr_sel_path    <= iss_sel_path;
			opr_sel_path_wb <= iss_sel_path_wb;
			opr_dst_idx     <= iss_dst_idx;
		end
	end

endmodule

`default_nettype wire

// File: lane_exec.sv
`default_nettype none

module lane_exec (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					opr_valid,
	input  tpu_ctrl_pkg::op_t		opr_op,
	input  tpu_data_pkg::data_t		opr_imm,
	input  tpu_data_pkg::data_t		opr_src1,
	input  tpu_data_pkg::data_t		opr_src2,
	input  tpu_data_pkg::data_t		opr_src3,
	input  tpu_ctrl_pkg::path_t		opr_sel_path,
	input  tpu_ctrl_pkg::path_t		opr_sel_path_wb,
	input  tpu_data_pkg::index_t	opr_dst_idx,
	output logic					out_valid,
	output tpu_data_pkg::index_t	wb_idx,
	output tpu_data_pkg::data_t		wb_data,
	output tpu_data_pkg::data_t		pac_data
);

	tpu_data_pkg::data_t	alu_res;
	tpu_data_pkg::data_t	wb_nxt;
	tpu_data_pkg::data_t	pac_nxt;

	// Operand pick shared by both muxes
	// Path 0 returns the fallback
	function automatic tpu_data_pkg::data_t pick(input tpu_ctrl_pkg::path_t sel,
			input tpu_data_pkg::data_t dflt);
		case (sel)
			tpu_ctrl_pkg::PATH_SRC1: return opr_src1;
			tpu_ctrl_pkg::PATH_SRC2: return opr_src2;
			tpu_ctrl_pkg::PATH_SRC3: return opr_src3;
			tpu_ctrl_pkg::PATH_ALU:  return dflt;
			default:                 return dflt;
		endcase
	endfunction

	always_comb begin
		case (opr_op)
			tpu_ctrl_pkg::OP_ADD: alu_res = opr_src1 + opr_src2;
			tpu_ctrl_pkg::OP_SUB: alu_res = opr_src1 - opr_src2;
			tpu_ctrl_pkg::OP_MUL: alu_res = opr_src1 * opr_src2;	// Low word
			tpu_ctrl_pkg::OP_MAD: alu_res = opr_src1 * opr_src2 + opr_src3;
			tpu_ctrl_pkg::OP_IMM: alu_res = opr_imm;
			default:              alu_res = '0;
		endcase
	end

	always_comb begin
		wb_nxt  = pick(opr_sel_path_wb, alu_res);	// Move or ALU result
		pac_nxt = pick(opr_sel_path, '0);			// Zero when no PAC source
	end

	always_ff @(posedge clock) begin
		if (rst)
			out_valid <= 1'b0;
		else if (!stall)
			out_valid <= opr_valid;				// Held high under stall
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			wb_idx   <= opr_dst_idx;
			wb_data  <= wb_nxt;
			pac_data <= pac_nxt;
		end
	end

endmodule

`default_nettype wire

// File: lane_top.sv
`default_nettype none

module lane_top #(
	parameter int BUFF_SIZE = tpu_ctrl_pkg::BYPASS_BUFF_SIZE
) (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					req,
	input  tpu_ctrl_pkg::op_t		op,
	input  tpu_data_pkg::data_t		imm,
	input  tpu_ctrl_pkg::path_t		sel_path,
	input  tpu_ctrl_pkg::path_t		sel_path_wb,
	input  tpu_data_pkg::index_t	src_idx1,
	input  tpu_data_pkg::index_t	src_idx2,
	input  tpu_data_pkg::index_t	src_idx3,
	input  tpu_data_pkg::index_t	dst_idx,
	output logic					out_valid,
	output tpu_data_pkg::index_t	wb_idx,
	output tpu_data_pkg::data_t		wb_data,
	output tpu_data_pkg::data_t		pac_data,
	output logic					buff_full
);

	//////////////////////////////////////////////////////////////
	// Stage nets
	//////////////////////////////////////////////////////////////

	logic					iss_valid;				// Issue stage
	tpu_ctrl_pkg::op_t		iss_op;
	tpu_data_pkg::data_t	iss_imm;
	tpu_ctrl_pkg::path_t	iss_sel_path;
	tpu_ctrl_pkg::path_t	iss_sel_path_wb;
	tpu_data_pkg::index_t	iss_src_idx1;
	tpu_data_pkg::index_t	iss_src_idx2;
	tpu_data_pkg::index_t	iss_src_idx3;
	tpu_data_pkg::index_t	iss_dst_idx;
	tpu_data_pkg::index_t	rd_idx1;				// RF read ports
	tpu_data_pkg::index_t	rd_idx2;
	tpu_data_pkg::index_t	rd_idx3;
	tpu_data_pkg::data_t	rd_data1;
	tpu_data_pkg::data_t	rd_data2;
	tpu_data_pkg::data_t	rd_data3;
	logic					ret_valid;				// Retire port
	tpu_data_pkg::index_t	ret_idx;
	tpu_data_pkg::data_t	ret_data;
	logic					opr_valid;				// Operand stage
	tpu_ctrl_pkg::op_t		opr_op;
	tpu_data_pkg::data_t	opr_imm;
	tpu_data_pkg::data_t	opr_src1;
	tpu_data_pkg::data_t	opr_src2;
	tpu_data_pkg::data_t	opr_src3;
	tpu_ctrl_pkg::path_t	opr_sel_path;
	tpu_ctrl_pkg::path_t	opr_sel_path_wb;
	tpu_data_pkg::index_t	opr_dst_idx;

	lane_issue i_lane_issue (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.req			(req),
		.buff_full		(buff_full),
		.op				(op),
		.imm			(imm),
		.sel_path		(sel_path),
		.sel_path_wb	(sel_path_wb),
		.src_idx1		(src_idx1),
		.src_idx2		(src_idx2),
		.src_idx3		(src_idx3),
		.dst_idx		(dst_idx),
		.rd_idx1		(rd_idx1),
		.rd_idx2		(rd_idx2),
		.rd_idx3		(rd_idx3),
		.ret_valid		(ret_valid),
		.ret_idx		(ret_idx),
		.ret_data		(ret_data),
		.iss_valid		(iss_valid),
		.iss_op			(iss_op),
		.iss_imm		(iss_imm),
		.iss_sel_path	(iss_sel_path),
		.iss_sel_path_wb(iss_sel_path_wb),
		.iss_src_idx1	(iss_src_idx1),
		.iss_src_idx2	(iss_src_idx2),
		.iss_src_idx3	(iss_src_idx3),
		.iss_dst_idx	(iss_dst_idx),
		.rd_data1		(rd_data1),
		.rd_data2		(rd_data2),
		.rd_data3		(rd_data3)
	);

	operand_network #(
		.BUFF_SIZE		(BUFF_SIZE)
	) i_operand_network (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.iss_valid		(iss_valid),
		.iss_op			(iss_op),
		.iss_imm		(iss_imm),
		.iss_sel_path	(iss_sel_path),
		.iss_sel_path_wb(iss_sel_path_wb),
		.iss_src_idx1	(iss_src_idx1),
		.iss_src_idx2	(iss_src_idx2),
		.iss_src_idx3	(iss_src_idx3),
		.iss_dst_idx	(iss_dst_idx),
		.rd_data1		(rd_data1),
		.rd_data2		(rd_data2),
		.rd_data3		(rd_data3),
		.wb_valid		(out_valid),			// Results feed the buffer
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.rd_idx1		(rd_idx1),
		.rd_idx2		(rd_idx2),
		.rd_idx3		(rd_idx3),
		.opr_valid		(opr_valid),
		.opr_op			(opr_op),
		.opr_imm		(opr_imm),
		.opr_src1		(opr_src1),
		.opr_src2		(opr_src2),
		.opr_src3		(opr_src3),
		.opr_sel_path	(opr_sel_path),
		.opr_sel_path_wb(opr_sel_path_wb),
		.opr_dst_idx	(opr_dst_idx),
		.buff_full		(buff_full),
		.ret_valid		(ret_valid),
		.ret_idx		(ret_idx),
		.ret_data		(ret_data)
	);

	lane_exec i_lane_exec (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.opr_valid		(opr_valid),
		.opr_op			(opr_op),
		.opr_imm		(opr_imm),
		.opr_src1		(opr_src1),
		.opr_src2		(opr_src2),
		.opr_src3		(opr_src3),
		.opr_sel_path	(opr_sel_path),
		.opr_sel_path_wb(opr_sel_path_wb),
		.opr_dst_idx	(opr_dst_idx),
		.out_valid		(out_valid),
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.pac_data		(pac_data)
	);

endmodule

`default_nettype wire

// File: lane_checker.sv
`default_nettype none

module lane_checker #(
	parameter int BUFF_SIZE = tpu_ctrl_pkg::BYPASS_BUFF_SIZE
) (
	input  logic					clock,
	input  logic					rst,
	input  logic					stall,
	input  logic					req,
	input  tpu_ctrl_pkg::op_t		op,
	input  tpu_data_pkg::data_t		imm,
	input  tpu_ctrl_pkg::path_t		sel_path,
	input  tpu_ctrl_pkg::path_t		sel_path_wb,
	input  tpu_data_pkg::index_t	src_idx1,
	input  tpu_data_pkg::index_t	src_idx2,
	input  tpu_data_pkg::index_t	src_idx3,
	input  tpu_data_pkg::index_t	dst_idx,
	input  logic					out_valid,
	input  tpu_data_pkg::index_t	wb_idx,
	input  tpu_data_pkg::data_t		wb_data,
	input  tpu_data_pkg::data_t		pac_data,
	input  logic					buff_full,
	output int						err_cnt,
	output int						chk_cnt,
	output logic					idle			// Nothing in flight
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		tpu_data_pkg::index_t	idx;
		tpu_data_pkg::data_t	wb;
		tpu_data_pkg::data_t	pac;
	} result_t;

	tpu_data_pkg::data_t	model_rf [tpu_data_pkg::NUM_REGS];	// Values of all risen results
	result_t				exp_q [$];			// Risen and not yet taken by the buffer
	result_t				p0;					// Sampled one advance ago
	result_t				p1;					// Sampled two advances ago
	logic					p0_v = 1'b0;
	logic					p1_v = 1'b0;
	int						occ = 0;			// Bypass buffer occupancy
	int						errors = 0;
	int						checks = 0;

	assign err_cnt = errors;
	assign chk_cnt = checks;

	//////////////////////////////////////////////////////////////
	// Reference function
	//////////////////////////////////////////////////////////////

	function automatic void ref_result(input tpu_ctrl_pkg::op_t f_op,
			input tpu_data_pkg::data_t f_imm, input tpu_data_pkg::data_t s1,
			input tpu_data_pkg::data_t s2, input tpu_data_pkg::data_t s3,
			input tpu_ctrl_pkg::path_t f_sel, input tpu_ctrl_pkg::path_t f_sel_wb,
			output tpu_data_pkg::data_t wb, output tpu_data_pkg::data_t pac);
		logic [63:0]			prod;
		tpu_data_pkg::data_t	alu;
		tpu_data_pkg::data_t	opnd [4];
		prod = {32'd0, s1} * {32'd0, s2};		// Full 64-bit product
		case (f_op)
			tpu_ctrl_pkg::OP_ADD: alu = s1 + s2;
			tpu_ctrl_pkg::OP_SUB: alu = s1 + ~s2 + 32'd1;	// Two's complement
			tpu_ctrl_pkg::OP_MUL: alu = prod[31:0];
			tpu_ctrl_pkg::OP_MAD: alu = prod[31:0] + s3;
			tpu_ctrl_pkg::OP_IMM: alu = f_imm;
			default:              alu = '0;
		endcase
		opnd[0] = alu;
		opnd[1] = s1;
		opnd[2] = s2;
		opnd[3] = s3;
		wb  = opnd[f_sel_wb];					// Path 0 is the ALU
		pac = (f_sel == 2'd0) ? '0 : opnd[f_sel];	// Path 0 sends nothing
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			errors++;
			$display("FAIL at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Model and compare on pre-edge values at every rising edge
	//////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		tpu_data_pkg::data_t	exp_wb;
		tpu_data_pkg::data_t	exp_pac;
		if (rst) begin
			for (int i = 0; i < tpu_data_pkg::NUM_REGS; i++)
				model_rf[i] = '0;
			exp_q.delete();
			p0_v = 1'b0;
			p1_v = 1'b0;
			occ  = 0;
		end else begin
			check_val("out_valid", 32'(exp_q.size() != 0), 32'(out_valid));
			check_val("buff_full", 32'(occ == BUFF_SIZE), 32'(buff_full));
			if (out_valid === 1'b1 && exp_q.size() != 0) begin	// Also holds under stall
				check_val("wb_idx", 32'(exp_q[0].idx), 32'(wb_idx));
				check_val("wb_data", exp_q[0].wb, wb_data);
				check_val("pac_data", exp_q[0].pac, pac_data);
			end
			if (!stall) begin					// Lane advances
				occ = occ + int'(exp_q.size() != 0) - int'(occ > 0);
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());	// Taken into the buffer
				if (p1_v) begin					// Rises at this edge
					model_rf[p1.idx] = p1.wb;
					exp_q.push_back(p1);
				end
				p1   = p0;
				p1_v = p0_v;
				p0_v = (req === 1'b1);
				if (p0_v) begin					// Sees everything risen so far
					ref_result(op, imm, model_rf[src_idx1], model_rf[src_idx2],
						model_rf[src_idx3], sel_path, sel_path_wb, exp_wb, exp_pac);
					p0.idx = dst_idx;
					p0.wb  = exp_wb;
					p0.pac = exp_pac;
				end
			end
		end
		idle = !p0_v && !p1_v && (exp_q.size() == 0);
	end

endmodule

`default_nettype wire

// File: tb_lane.sv
`default_nettype none

module tb_lane;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int BUFF_SIZE = tpu_ctrl_pkg::BYPASS_BUFF_SIZE;
	localparam int N_LOADS   = 16;				// One immediate load per register
	localparam int N_MIXED   = 300;
	localparam int WAIT_MAX  = 50;				// Cycles per wait loop

	logic					clock = 1'b0;
	logic					rst;
	logic					stall;
	logic					req;
	tpu_ctrl_pkg::op_t		op;
	tpu_data_pkg::data_t	imm;
	tpu_ctrl_pkg::path_t	sel_path;
	tpu_ctrl_pkg::path_t	sel_path_wb;
	tpu_data_pkg::index_t	src_idx1;
	tpu_data_pkg::index_t	src_idx2;
	tpu_data_pkg::index_t	src_idx3;
	tpu_data_pkg::index_t	dst_idx;
	logic					out_valid;
	tpu_data_pkg::index_t	wb_idx;
	tpu_data_pkg::data_t	wb_data;
	tpu_data_pkg::data_t	pac_data;
	logic					buff_full;
	int						err_cnt;
	int						chk_cnt;
	logic					chk_idle;
	integer					seed = 32'h8988_e734;
	int						stall_left = 0;		// Cycles left in current stall pulse
	bit						timed_out = 1'b0;

	always #50 clock = ~clock;

	lane_top #(
		.BUFF_SIZE		(BUFF_SIZE)
	) i_lane_top (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.req			(req),
		.op				(op),
		.imm			(imm),
		.sel_path		(sel_path),
		.sel_path_wb	(sel_path_wb),
		.src_idx1		(src_idx1),
		.src_idx2		(src_idx2),
		.src_idx3		(src_idx3),
		.dst_idx		(dst_idx),
		.out_valid		(out_valid),
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.pac_data		(pac_data),
		.buff_full		(buff_full)
	);

	lane_checker #(
		.BUFF_SIZE		(BUFF_SIZE)
	) i_lane_checker (
		.clock			(clock),
		.rst			(rst),
		.stall			(stall),
		.req			(req),
		.op				(op),
		.imm			(imm),
		.sel_path		(sel_path),
		.sel_path_wb	(sel_path_wb),
		.src_idx1		(src_idx1),
		.src_idx2		(src_idx2),
		.src_idx3		(src_idx3),
		.dst_idx		(dst_idx),
		.out_valid		(out_valid),
		.wb_idx			(wb_idx),
		.wb_data		(wb_data),
		.pac_data		(pac_data),
		.buff_full		(buff_full),
		.err_cnt		(err_cnt),
		.chk_cnt		(chk_cnt),
		.idle			(chk_idle)
	);

	//////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////

	// Occasional stall pulses of 1 to 12 cycles
	task automatic update_stall();
		if (stall_left > 0)
			stall_left = stall_left - 1;
		else if (({$random(seed)} % 16) == 0)
			stall_left = 1 + ({$random(seed)} % 12);
		stall = (stall_left > 0);
	endtask

	task automatic set_fields(input int n);
		if (n < N_LOADS) begin
			op          = tpu_ctrl_pkg::OP_IMM;
			dst_idx     = tpu_data_pkg::index_t'(n);
			src_idx1    = tpu_data_pkg::index_t'(n);	// Not loaded yet, reads reset value
			sel_path    = tpu_ctrl_pkg::PATH_SRC1;
			sel_path_wb = tpu_ctrl_pkg::PATH_ALU;
		end else begin
			op          = tpu_ctrl_pkg::op_t'(3'({$random(seed)} % 5));
			dst_idx     = 4'($random(seed) & 32'h7);	// Narrow range for hazards
			src_idx1    = 4'($random(seed) & 32'h7);
			sel_path    = 2'($random(seed));
			if (({$random(seed)} % 4) == 0)
				sel_path_wb = 2'($random(seed));		// Some moves
			else
				sel_path_wb = tpu_ctrl_pkg::PATH_ALU;
		end
		src_idx2 = 4'($random(seed) & 32'h7);
		src_idx3 = 4'($random(seed));
		imm      = $random(seed);
	endtask

	// One falling edge, request n goes out only if allowed
	task automatic drive_cycle(input int n, output bit issued);
		@(negedge clock);
		update_stall();
		req    = 1'b0;
		issued = 1'b0;
		if (!stall && !buff_full && (({$random(seed)} % 8) != 0)) begin
			set_fields(n);
			req    = 1'b1;
			issued = 1'b1;
		end
	endtask

	task automatic finish_run(input bit timeout_seen);
		$display("Summary: %0d checks, %0d errors, %0d timeouts", chk_cnt, err_cnt,
			int'(timeout_seen));
		if (!timeout_seen && err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		bit issued;
		int waited;
		rst         = 1'b1;
		stall       = 1'b0;
		req         = 1'b0;
		op          = tpu_ctrl_pkg::OP_ADD;
		imm         = '0;
		sel_path    = tpu_ctrl_pkg::PATH_ALU;
		sel_path_wb = tpu_ctrl_pkg::PATH_ALU;
		src_idx1    = '0;
		src_idx2    = '0;
		src_idx3    = '0;
		dst_idx     = '0;
		repeat (4) @(negedge clock);			// Four reset cycles
		rst = 1'b0;

		for (int n = 0; n < N_LOADS + N_MIXED && !timed_out; n++) begin
			issued = 1'b0;
			waited = 0;
			while (!issued && waited < WAIT_MAX) begin
				drive_cycle(n, issued);
				waited++;
			end
			if (!issued) begin
				$display("Timeout: request %0d was not issued within %0d cycles", n, WAIT_MAX);
				timed_out = 1'b1;
			end
		end

		if (!timed_out) begin					// Drain the pipe
			@(negedge clock);
			req        = 1'b0;
			stall_left = 0;
			stall      = 1'b0;
			waited     = 0;
			while (!chk_idle && waited < WAIT_MAX) begin
				@(negedge clock);
				waited++;
			end
			if (!chk_idle) begin
				$display("Timeout: results still pending after %0d cycles of drain", WAIT_MAX);
				timed_out = 1'b1;
			end
			repeat (2) @(negedge clock);		// Catch a late out_valid
		end
		finish_run(timed_out);
	end

endmodule

`default_nettype wire

// File: flist.f
tpu_data_pkg.sv
tpu_ctrl_pkg.sv
lane_issue.sv
bypass_buff.sv
operand_network.sv
lane_exec.sv
lane_top.sv
lane_checker.sv
tb_lane.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_lane -f flist.f \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_lane > sim.log 2>&1
cat sim.log

grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
